// ==== files.f ====
+incdir+.
lsu_pkg.sv
lsu_req_decode.sv
lsu_issue_ctrl.sv
lsu_rdata_align.sv
lsu_top.sv
lsu_checker.sv
lsu_tb.sv

// ==== lsu_checker.sv ====
// lsu bus checker: concurrent assertions on counter range, response legality, request stability
`default_nettype none

`include "lsu_params.svh"

module lsu_checker (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [`LSU_CNTW-1:0]  cnt_i,         // outstanding counter inside the issue block
  input  logic                  data_req_i,
  input  logic                  data_gnt_i,
  input  logic                  data_rvalid_i,
  input  lsu_pkg::lsu_bus_req_t data_bus_i
);

  ////////////////////////////////////////
  // bus rules
  ////////////////////////////////////////

  cnt_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    cnt_i <= `LSU_DEPTH)
    else $error("outstanding counter above depth");

  // every response needs a granted request in flight
  rvalid_legal: assert property (@(posedge clk) disable iff (!rst_n)
    data_rvalid_i |-> (cnt_i != '0))
    else $error("rvalid with nothing outstanding");

  req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (data_req_i && !data_gnt_i) |=> (data_req_i && $stable(data_bus_i)))
    else $error("address phase changed before grant");

  be_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
    data_req_i |-> (data_bus_i.be != '0))
    else $error("request without byte enables");

endmodule

// attach to every lsu_top
bind lsu_top lsu_checker chk0 (
  .clk           (clk),
  .rst_n         (rst_n),
  .cnt_i         (u_issue.cnt_q),
  .data_req_i    (data_req_o),
  .data_gnt_i    (data_gnt_i),
  .data_rvalid_i (data_rvalid_i),
  .data_bus_i    (data_bus_o)
);

`default_nettype wire

// ==== lsu_issue_ctrl.sv ====
// transaction issue: outstanding counter, request gating, bus drive, ready and busy generation
`default_nettype none

`include "lsu_params.svh"

module lsu_issue_ctrl (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  req_valid_i,
  input  lsu_pkg::lsu_bus_req_t bus_req_i,
  input  logic                  data_gnt_i,
  input  logic                  data_rvalid_i,
  output logic                  data_req_o,
  output lsu_pkg::lsu_bus_req_t data_bus_o,
  output logic                  ctrl_update_o,  // ex request moves on to writeback
  output logic                  ready_ex_o,
  output logic                  ready_wb_o,
  output logic                  busy_o
);

  localparam logic [`LSU_CNTW-1:0] DEPTH    = `LSU_DEPTH;
  localparam logic [`LSU_CNTW-1:0] CNT_ZERO = '0;
  localparam logic [`LSU_CNTW-1:0] CNT_ONE  = 1;

  logic [`LSU_CNTW-1:0] cnt_q;  // accepted requests still waiting for rvalid
  logic [`LSU_CNTW-1:0] cnt_d;
  logic                 trans_valid;
  logic                 accepted;   // req and gnt in the same cycle

  ////////////////////////////////////////
  // request side
  ////////////////////////////////////////
  assign trans_valid = req_valid_i && (cnt_q < DEPTH);  // no combinational path from rvalid
  assign accepted    = trans_valid && data_gnt_i;

  assign data_req_o = trans_valid;
  assign data_bus_o = bus_req_i;  // held stable by the ex stage until ready_ex_o

  // wb free when empty, else when its response shows up
  assign ready_wb_o = (cnt_q == CNT_ZERO) ? 1'b1 : data_rvalid_i;

  // ex and wb advance in lock step once wb is occupied
  always_comb begin
    if (!req_valid_i) begin
      ready_ex_o = 1'b1;
    end else if (cnt_q == CNT_ZERO) begin
      ready_ex_o = accepted;
    end else if (cnt_q == CNT_ONE) begin
      ready_ex_o = accepted && data_rvalid_i;
    end else begin
      ready_ex_o = data_rvalid_i;  // full, request was granted earlier
    end
  end

  assign ctrl_update_o = ready_ex_o && req_valid_i;
  assign busy_o        = (cnt_q != CNT_ZERO) || trans_valid;

  ////////////////////////////////////////
  // outstanding counter
  ////////////////////////////////////////
  always_comb begin
    case ({accepted, data_rvalid_i})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;  // idle, or one in and one out
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

endmodule

`default_nettype wire

// ==== lsu_params.svh ====
// lsu width, byte-enable, outstanding-depth and counter-width macros
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

////////////////////////////////////////
// datapath widths
////////////////////////////////////////

// data and address word
`define LSU_DW 32

// one enable per byte lane
`define LSU_BEW 4

////////////////////////////////////////
// bus pipelining
////////////////////////////////////////

// max transactions in flight on the data bus
`define LSU_DEPTH 2

// outstanding counter, must hold 0..LSU_DEPTH
`define LSU_CNTW 2

`endif

// ==== lsu_pkg.sv ====
// lsu package: size and extension enums, word and be types, request, bus and writeback structs
`default_nettype none

`include "lsu_params.svh"

package lsu_pkg;

  typedef logic [`LSU_DW-1:0]  lsu_word_t;  // data or address word
  typedef logic [`LSU_BEW-1:0] lsu_be_t;    // byte enables, bit i = lane i

  // access size, encoding as in the core decoder
  typedef enum logic [1:0] {
    SIZE_WORD = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_BYTE = 2'b10   // 2'b11 decodes as byte as well
  } lsu_size_e;

  // load extension of half and byte results
  typedef enum logic [1:0] {
    EXT_ZERO = 2'b00,
    EXT_SIGN = 2'b01,   // also taken for the spare code 2'b11
    EXT_ONES = 2'b10
  } lsu_ext_e;

  ////////////////////////////////////////
  // request from the ex stage
  ////////////////////////////////////////
  typedef struct packed {
    logic       we;          // 1 = store
    lsu_size_e  size;
    lsu_ext_e   ext;
    logic [1:0] reg_offset;  // byte offset of store data inside the register
    lsu_word_t  wdata;
    lsu_word_t  operand_a;   // base address
    lsu_word_t  operand_b;   // offset, only with use_incr
    logic       use_incr;    // address = a + b, else a
  } lsu_req_t;

  // bus address phase
  typedef struct packed {
    lsu_word_t addr;
    logic      we;
    lsu_be_t   be;
    lsu_word_t wdata;  // already rotated into byte lanes
  } lsu_bus_req_t;

  // what writeback needs to know once the response arrives
  typedef struct packed {
    lsu_size_e  size;
    logic [1:0] offset;  // low address bits of the access
    lsu_ext_e   ext;
    logic       we;
  } lsu_wb_ctrl_t;

endpackage

`default_nettype wire

// ==== lsu_rdata_align.sv ====
// read-data alignment: writeback control register, lane select, split-load join, extension, hold
`default_nettype none

module lsu_rdata_align (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  ctrl_update_i,
  input  lsu_pkg::lsu_wb_ctrl_t wb_next_i,
  input  logic                  misaligned_i,  // first phase of a split load is returning
  input  logic                  data_rvalid_i,
  input  lsu_pkg::lsu_word_t    data_rdata_i,
  output lsu_pkg::lsu_word_t    rdata_o
);

  lsu_pkg::lsu_wb_ctrl_t wb_q;     // control of the access now in writeback
  lsu_pkg::lsu_word_t    rdata_q;  // first-phase word or last result
  lsu_pkg::lsu_word_t    word_al;  // word after joining split halves
  lsu_pkg::lsu_word_t    result;
  logic [15:0]           half_raw;
  logic [7:0]            byte_raw;

  // bit to fill the upper result bits with
  function automatic logic fill_bit(lsu_pkg::lsu_ext_e ext, logic msb);
    case (ext)
      lsu_pkg::EXT_ZERO: return 1'b0;
      lsu_pkg::EXT_ONES: return 1'b1;
      default:           return msb;  // sign
    endcase
  endfunction

  // capture on the cycle the request leaves ex
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_q <= '0;
    end else if (ctrl_update_i) begin
      wb_q <= wb_next_i;
    end
  end

  ////////////////////////////////////////
  // lane select
  ////////////////////////////////////////
  always_comb begin
    case (wb_q.offset)  // for nonzero offset low bytes come from the held first word
      2'b00:   word_al = data_rdata_i;
      2'b01:   word_al = {data_rdata_i[7:0],  rdata_q[31:8]};
      2'b10:   word_al = {data_rdata_i[15:0], rdata_q[31:16]};
      default: word_al = {data_rdata_i[23:0], rdata_q[31:24]};
    endcase
  end

  always_comb begin
    case (wb_q.offset)
      2'b00:   half_raw = data_rdata_i[15:0];
      2'b01:   half_raw = data_rdata_i[23:8];
      2'b10:   half_raw = data_rdata_i[31:16];
      default: half_raw = {data_rdata_i[7:0], rdata_q[31:24]};  // straddles two words
    endcase
  end

  assign byte_raw = data_rdata_i[8*wb_q.offset +: 8];

  ////////////////////////////////////////
  // extension
  ////////////////////////////////////////
  always_comb begin
    case (wb_q.size)
      lsu_pkg::SIZE_WORD: result = word_al;
      lsu_pkg::SIZE_HALF: result = {{16{fill_bit(wb_q.ext, half_raw[15])}}, half_raw};
      default:            result = {{24{fill_bit(wb_q.ext, byte_raw[7])}}, byte_raw};
    endcase
  end

  // stores leave the held value alone
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata_q <= '0;
    end else if (data_rvalid_i && !wb_q.we) begin
      if (misaligned_i) begin
        rdata_q <= data_rdata_i;  // raw word, joined on the second response
      end else begin
        rdata_q <= result;
      end
    end
  end

  assign rdata_o = data_rvalid_i ? result : rdata_q;  // live in the rvalid cycle, then held

endmodule

`default_nettype wire

// ==== lsu_req_decode.sv ====
// request decode: address generation, misalignment detection, byte enables, store-data rotation
`default_nettype none

module lsu_req_decode (
  input  logic                  req_valid_i,
  input  lsu_pkg::lsu_req_t     req_i,
  input  logic                  misaligned_ex_i,  // second phase of a split access
  output lsu_pkg::lsu_bus_req_t bus_req_o,
  output lsu_pkg::lsu_wb_ctrl_t wb_next_o,
  output logic                  misaligned_o
);

  lsu_pkg::lsu_word_t addr;       // effective byte address
  logic [1:0]         off;        // byte offset inside the word
  logic [1:0]         wdata_rot;  // lane rotation of store data
  lsu_pkg::lsu_be_t   be;
  lsu_pkg::lsu_word_t wdata;

  ////////////////////////////////////////
  // address
  ////////////////////////////////////////
  assign addr = req_i.use_incr ? (req_i.operand_a + req_i.operand_b) : req_i.operand_a;
  assign off  = addr[1:0];

  ////////////////////////////////////////
  // byte enables
  ////////////////////////////////////////
  always_comb begin
    case (req_i.size)
      lsu_pkg::SIZE_WORD: begin
        if (!misaligned_ex_i) begin
          case (off)  // upper part of the word lands in this access
            2'b00:   be = 4'b1111;
            2'b01:   be = 4'b1110;
            2'b10:   be = 4'b1100;
            default: be = 4'b1000;
          endcase
        end else begin
          case (off)  // remaining low lanes of the next word
            2'b00:   be = 4'b0000;  // never split, kept for completeness
            2'b01:   be = 4'b0001;
            2'b10:   be = 4'b0011;
            default: be = 4'b0111;
          endcase
        end
      end
      lsu_pkg::SIZE_HALF: begin
        if (!misaligned_ex_i) begin
          case (off)
            2'b00:   be = 4'b0011;
            2'b01:   be = 4'b0110;
            2'b10:   be = 4'b1100;
            default: be = 4'b1000;  // offset 3, high byte follows
          endcase
        end else begin
          be = 4'b0001;  // only lane 0 left over
        end
      end
      default: begin  // byte, both upper codes
        case (off)
          2'b00:   be = 4'b0001;
          2'b01:   be = 4'b0010;
          2'b10:   be = 4'b0100;
          default: be = 4'b1000;
        endcase
      end
    endcase
  end

  // store data moves from its register offset to the address offset
  assign wdata_rot = off - req_i.reg_offset;

  always_comb begin
    case (wdata_rot)
      2'b00:   wdata = req_i.wdata;
      2'b01:   wdata = {req_i.wdata[23:0], req_i.wdata[31:24]};
      2'b10:   wdata = {req_i.wdata[15:0], req_i.wdata[31:16]};
      default: wdata = {req_i.wdata[7:0],  req_i.wdata[31:8]};
    endcase
  end

  // split access: word off alignment, or half straddling lanes 3 and 0
  always_comb begin
    misaligned_o = 1'b0;
    if (req_valid_i && !misaligned_ex_i) begin
      case (req_i.size)
        lsu_pkg::SIZE_WORD: misaligned_o = (off != 2'b00);
        lsu_pkg::SIZE_HALF: misaligned_o = (off == 2'b11);
        default:            misaligned_o = 1'b0;  // bytes never split
      endcase
    end
  end

  always_comb begin
    bus_req_o.addr  = misaligned_ex_i ? {addr[31:2], 2'b00} : addr;  // 2nd phase word aligned
    bus_req_o.we    = req_i.we;
    bus_req_o.be    = be;
    bus_req_o.wdata = wdata;
    wb_next_o.size   = req_i.size;
    wb_next_o.offset = off;
    wb_next_o.ext    = req_i.ext;
    wb_next_o.we     = req_i.we;
  end

endmodule

`default_nettype wire

// ==== lsu_tb.sv ====
// lsu testbench with clock, reset, lfsr-timed memory model, file-driven controller, monitor and watchdog
`default_nettype none

module lsu_tb;

  logic                  clk;
  logic                  rst_n;
  logic                  req_valid_i;
  lsu_pkg::lsu_req_t     req_i;
  logic                  misaligned_ex_i;
  logic                  ready_ex_o;
  logic                  ready_wb_o;
  logic                  busy_o;
  logic                  misaligned_o;
  lsu_pkg::lsu_word_t    rdata_o;
  logic                  data_req_o;
  lsu_pkg::lsu_bus_req_t data_bus_o;
  logic                  data_gnt_i;
  logic                  data_rvalid_i;
  lsu_pkg::lsu_word_t    data_rdata_i;

  lsu_top dut0 (.*);

  // test table filled from lsu_tests.txt
  lsu_pkg::lsu_req_t  t_req [64];
  lsu_pkg::lsu_be_t   t_be  [64];
  lsu_pkg::lsu_word_t t_res [64];
  int                 n_tests = 0;

  // expected responses in bus order
  bit                 exp_final [$];  // last phase of an access
  bit                 exp_load  [$];
  lsu_pkg::lsu_word_t exp_data  [$];

  // memory model state
  lsu_pkg::lsu_word_t mem [64];
  lsu_pkg::lsu_word_t resp_data [$];
  int                 resp_due  [$];  // cycle from which rvalid may show
  logic [1:0]         gnt_wait;       // req cycles left before grant
  int                 cyc = 0;
  logic [31:0]        lfsr = 32'h5cf2_af4e;

  int                 out_cnt = 0;    // shadow of the outstanding count
  bit                 hold_valid = 0;
  lsu_pkg::lsu_word_t hold_data;

  always #50 clk = ~clk;

  ////////////////////////////////////////
  // random delays
  ////////////////////////////////////////

  // galois lfsr stepped once per bit
  function automatic logic lfsr_bit();
    logic b;
    b    = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) lfsr = lfsr ^ 32'h8020_0003;
    return b;
  endfunction

  function automatic logic [1:0] rand_delay();
    logic [1:0] d;
    d[0] = lfsr_bit();
    d[1] = lfsr_bit();
    return d;
  endfunction

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  task automatic abort_run(input string what);
    $display("ERROR at %0t: %s", $time, what);
    $display("Test FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_word(input string name, input lsu_pkg::lsu_word_t got,
                            input lsu_pkg::lsu_word_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("Test FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic check_be(input string name, input lsu_pkg::lsu_be_t got,
                          input lsu_pkg::lsu_be_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
      $display("Test FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
      $display("Test FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  ////////////////////////////////////////
  // memory model
  ////////////////////////////////////////

  // inputs have settled by the negedge
  always @(negedge clk) begin
    logic [5:0] idx;
    if (rst_n) begin
      if (data_rvalid_i) begin
        void'(resp_data.pop_front());
        void'(resp_due.pop_front());
      end
      if (data_req_o && data_gnt_i) begin
        idx = data_bus_o.addr[7:2];
        if (data_bus_o.we) begin
          for (int b = 0; b < 4; b++) begin
            if (data_bus_o.be[b]) mem[idx][8*b +: 8] = data_bus_o.wdata[8*b +: 8];
          end
        end
        resp_data.push_back(mem[idx]);  // read taken at grant to keep bus order
        resp_due.push_back(cyc + 1 + int'(rand_delay()));
        gnt_wait = rand_delay();
      end else if (data_req_o && gnt_wait != 2'd0) begin
        gnt_wait = gnt_wait - 2'd1;
      end
      cyc = cyc + 1;
    end
  end

  always @(posedge clk) begin
    #10;
    data_gnt_i = (gnt_wait == 2'd0);
    if (resp_data.size() != 0 && resp_due[0] <= cyc) begin
      data_rvalid_i = 1'b1;
      data_rdata_i  = resp_data[0];
    end else begin
      data_rvalid_i = 1'b0;
      data_rdata_i  = '0;
    end
  end

  ////////////////////////////////////////
  // response monitor
  ////////////////////////////////////////
  always @(negedge clk) begin
    if (rst_n) begin
      if (out_cnt != 0) check_flag("busy_o", busy_o, 1'b1);  // transfer in flight
      check_flag("ready_wb_o", ready_wb_o, (out_cnt == 0) ? 1'b1 : data_rvalid_i);
      if (data_rvalid_i) begin
        if (exp_data.size() == 0) begin
          abort_run("rvalid arrived with no transfer outstanding");
        end else begin
          if (exp_final[0] && exp_load[0]) begin
            check_word("rdata_o", rdata_o, exp_data[0]);
            hold_data  = exp_data[0];
            hold_valid = 1;
          end else if (exp_load[0]) begin
            hold_valid = 0;  // first half of a split load leaves the raw word held
          end
          void'(exp_final.pop_front());
          void'(exp_load.pop_front());
          void'(exp_data.pop_front());
        end
      end else if (hold_valid) begin
        check_word("rdata_o (held)", rdata_o, hold_data);
      end
      if (data_req_o && data_gnt_i) out_cnt = out_cnt + 1;
      if (data_rvalid_i) out_cnt = out_cnt - 1;
    end
  end

  ////////////////////////////////////////
  // controller
  ////////////////////////////////////////

  // split when a word is off alignment or a half straddles lanes 3 and 0
  function automatic bit split_access(input int t);
    lsu_pkg::lsu_word_t a;
    a = t_req[t].use_incr ? (t_req[t].operand_a + t_req[t].operand_b) : t_req[t].operand_a;
    if (t_req[t].size == lsu_pkg::SIZE_WORD) return a[1:0] != 2'b00;
    if (t_req[t].size == lsu_pkg::SIZE_HALF) return a[1:0] == 2'b11;
    return 0;
  endfunction

  task automatic drive_req(input int t, input logic phase2);
    lsu_pkg::lsu_req_t r;
    r = t_req[t];
    if (phase2) r.operand_a = r.operand_a + 32'd4;  // next word
    @(posedge clk);
    #10;
    req_valid_i     = 1'b1;
    req_i           = r;
    misaligned_ex_i = phase2;
  endtask

  task automatic wait_accept(input int t, input logic phase2, input logic split);
    @(negedge clk);
    while (!ready_ex_o) @(negedge clk);
    if (!phase2) check_be("data_bus_o.be", data_bus_o.be, t_be[t]);
    check_flag("misaligned_o", misaligned_o, split && !phase2);
    exp_final.push_back(phase2 || !split);
    exp_load.push_back(!t_req[t].we);
    exp_data.push_back(t_res[t]);
  endtask

  task automatic drain();
    @(posedge clk);
    #10;
    req_valid_i     = 1'b0;
    misaligned_ex_i = 1'b0;
    @(negedge clk);
    while (busy_o || exp_data.size() != 0) @(negedge clk);
  endtask

  task automatic load_tests();
    int          fd;
    int          n;
    string       line;
    logic [31:0] f [10];
    fd = $fopen("lsu_tests.txt", "r");
    if (fd == 0) abort_run("cannot open lsu_tests.txt");
    while (!$feof(fd) && n_tests < 64) begin
      n = $fgets(line, fd);
      if (n > 1 && line.getc(0) != "#") begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
        if (n == 10) begin
          t_req[n_tests].we         = f[0][0];
          t_req[n_tests].size       = lsu_pkg::lsu_size_e'(f[1][1:0]);
          t_req[n_tests].ext        = lsu_pkg::lsu_ext_e'(f[2][1:0]);
          t_req[n_tests].reg_offset = f[3][1:0];
          t_req[n_tests].operand_a  = f[4];
          t_req[n_tests].operand_b  = f[5];
          t_req[n_tests].use_incr   = f[6][0];
          t_req[n_tests].wdata      = f[7];
          t_be[n_tests]             = f[8][3:0];
          t_res[n_tests]            = f[9];
          n_tests = n_tests + 1;
        end
      end
    end
    $fclose(fd);
  endtask

  initial begin
    bit split;
    clk             = 1'b0;
    rst_n           = 1'b0;
    req_valid_i     = 1'b0;
    req_i           = '0;
    misaligned_ex_i = 1'b0;
    data_gnt_i      = 1'b0;
    data_rvalid_i   = 1'b0;
    data_rdata_i    = '0;
    gnt_wait        = 2'd0;
    for (int i = 0; i < 64; i++) mem[i] = 32'h5a5a_0000 ^ (i * 32'h0001_0101);
    load_tests();
    repeat (5) @(posedge clk);
    #10;
    rst_n = 1'b1;
    @(negedge clk);
    check_flag("data_req_o", data_req_o, 1'b0);  // idle after reset
    check_flag("busy_o", busy_o, 1'b0);
    check_flag("ready_ex_o", ready_ex_o, 1'b1);
    check_flag("ready_wb_o", ready_wb_o, 1'b1);
    for (int t = 0; t < n_tests; t++) begin
      split = split_access(t);
      if (split) drain();  // split accesses need an empty bus around them
      drive_req(t, 1'b0);
      wait_accept(t, 1'b0, split);
      if (split) begin
        drive_req(t, 1'b1);
        wait_accept(t, 1'b1, split);
      end
    end
    drain();
    if (out_cnt != 0 || n_tests == 0) begin
      abort_run("bus not empty at the end, or no tests were read");
    end else begin
      $display("Test OK");
      $finish;
    end
  end

  // watchdog sized by the number of test lines
  initial begin
    wait (n_tests > 0);
    #((n_tests * 40 + 20) * 100);
    $display("watchdog expired, the run did not complete in time");
    $display("Test FAILED");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

// ==== lsu_tests.txt ====
# we size ext reg_offset operand_a operand_b use_incr wdata exp_be exp_result (all hex)
# size 0 word 1 half 2 byte, ext 0 zero 1 sign 2 ones, exp_result unused for stores
1 0 0 0 00000020 00000000 0 deadbeef f 00000000
1 2 0 0 0000001c 00000005 1 00000080 2 00000000
1 1 0 0 00000022 00000000 0 00007f01 c 00000000
0 0 0 0 00000020 00000000 0 00000000 f 7f0180ef
0 2 1 0 00000021 00000000 0 00000000 2 ffffff80
0 2 0 0 00000021 00000000 0 00000000 2 00000080
0 2 2 0 00000020 00000000 0 00000000 1 ffffffef
0 2 1 0 00000023 00000000 0 00000000 8 0000007f
0 1 1 0 00000022 00000000 0 00000000 c 00007f01
0 1 1 0 00000020 00000000 0 00000000 3 ffff80ef
0 1 0 0 00000021 00000000 0 00000000 6 00000180
0 1 2 0 00000020 00000000 0 00000000 3 ffff80ef
1 0 0 0 00000024 00000000 0 cafef00d f 00000000
0 0 0 0 00000022 00000000 0 00000000 c f00d7f01
0 1 1 0 00000023 00000000 0 00000000 8 00000d7f
0 1 2 0 00000023 00000000 0 00000000 8 ffff0d7f
0 0 0 0 00000021 00000000 0 00000000 e 0d7f0180
0 0 0 0 00000023 00000000 0 00000000 8 fef00d7f
1 0 0 0 00000028 00000000 0 00000000 f 00000000
1 0 0 0 0000002c 00000000 0 00000000 f 00000000
1 0 0 0 00000029 00000000 0 44332211 e 00000000
0 0 0 0 00000028 00000000 0 00000000 f 33221100
0 0 0 0 0000002c 00000000 0 00000000 f 00000044
0 0 0 0 00000029 00000000 0 00000000 e 44332211
1 0 0 0 00000030 00000000 0 12345678 f 00000000
1 1 0 0 0000002f 00000000 0 0000beef 8 00000000
0 0 0 0 0000002c 00000000 0 00000000 f ef000044
0 0 0 0 00000030 00000000 0 00000000 f 123456be
0 1 1 0 0000002f 00000000 0 00000000 8 ffffbeef
1 0 0 0 00000034 00000000 0 00000000 f 00000000
1 2 0 1 00000034 00000000 0 0000ab00 1 00000000
0 2 0 0 00000034 00000000 0 00000000 1 000000ab
0 2 1 0 00000034 00000000 0 00000000 1 ffffffab
0 0 0 0 00000020 00000000 0 00000000 f 7f0180ef
0 0 0 0 00000024 00000000 0 00000000 f cafef00d
0 0 0 0 00000028 00000000 0 00000000 f 33221100
0 0 0 0 00000030 00000000 0 00000000 f 123456be
0 2 1 0 00000024 00000002 1 00000000 4 fffffffe
0 1 0 0 00000024 00000000 0 00000000 3 0000f00d

// ==== lsu_top.sv ====
// lsu top level: request decode, transaction issue and read-data alignment
`default_nettype none

module lsu_top (
  input  logic                  clk,
  input  logic                  rst_n,
  // ex stage
  input  logic                  req_valid_i,
  input  lsu_pkg::lsu_req_t     req_i,
  input  logic                  misaligned_ex_i,
  output logic                  ready_ex_o,
  output logic                  ready_wb_o,
  output logic                  busy_o,
  output logic                  misaligned_o,
  output lsu_pkg::lsu_word_t    rdata_o,
  // data bus
  output logic                  data_req_o,
  output lsu_pkg::lsu_bus_req_t data_bus_o,
  input  logic                  data_gnt_i,
  input  logic                  data_rvalid_i,
  input  lsu_pkg::lsu_word_t    data_rdata_i
);

  lsu_pkg::lsu_bus_req_t bus_req;
  lsu_pkg::lsu_wb_ctrl_t wb_next;
  logic                  ctrl_update;
  logic                  misaligned_any;  // either phase of a split access

  assign misaligned_any = misaligned_ex_i | misaligned_o;

  lsu_req_decode u_decode (
    .req_valid_i     (req_valid_i),
    .req_i           (req_i),
    .misaligned_ex_i (misaligned_ex_i),
    .bus_req_o       (bus_req),
    .wb_next_o       (wb_next),
    .misaligned_o    (misaligned_o)
  );

  lsu_issue_ctrl u_issue (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_valid_i   (req_valid_i),
    .bus_req_i     (bus_req),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .data_req_o    (data_req_o),
    .data_bus_o    (data_bus_o),
    .ctrl_update_o (ctrl_update),
    .ready_ex_o    (ready_ex_o),
    .ready_wb_o    (ready_wb_o),
    .busy_o        (busy_o)
  );

  lsu_rdata_align u_align (
    .clk           (clk),
    .rst_n         (rst_n),
    .ctrl_update_i (ctrl_update),
    .wb_next_i     (wb_next),
    .misaligned_i  (misaligned_any),
    .data_rvalid_i (data_rvalid_i),
    .data_rdata_i  (data_rdata_i),
    .rdata_o       (rdata_o)
  );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build the lsu testbench with verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f files.f --top-module lsu_tb -o lsu_sim \
  && ./obj_dir/lsu_sim \
  || { echo "simulation build or run failed"; exit 1; }
